/* l1_trigger.f */
+incdir+hdl
+incdir+verif
hdl/l1_pkg.sv
hdl/beam_power.sv
hdl/trigger_servo.sv
hdl/l1_wb_regs.sv
hdl/l1_trigger_top.sv
verif/l1_trigger_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= l1_trigger_tb
FILELIST  ?= l1_trigger.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(BUILD_DIR)

/* verif/l1_tb_model.svh */
`ifndef L1_TB_MODEL_SVH
`define L1_TB_MODEL_SVH

`include "l1_consts.svh"

localparam int MODEL_DELAYS [`L1_NBEAMS][`L1_NCHAN] = `L1_BEAM_DELAYS;

// Sum of |beam sample| over one block, a delay of d takes sample n-d
function automatic int model_power(input l1_pkg::adc_block_t cur,
                                   input l1_pkg::adc_block_t prev, input int beam);
    l1_pkg::sample_t s;
    int              idx;
    int              sum;
    int              pow;
    pow = 0;
    for (int n = 0; n < `L1_NSAMP; n++) begin
        sum = 0;
        for (int ch = 0; ch < `L1_NCHAN; ch++) begin
            idx = n - MODEL_DELAYS[beam][ch];
            s   = (idx >= 0) ? cur[ch][idx] : prev[ch][idx + `L1_NSAMP];
            sum += s;
        end
        pow += (sum < 0) ? -sum : sum;
    end
    return pow;
endfunction

// Trigger when the power is strictly above the threshold
function automatic l1_pkg::beam_vec_t model_trigger(input l1_pkg::adc_block_t cur,
        input l1_pkg::adc_block_t prev, input l1_pkg::thresh_t [`L1_NBEAMS-1:0] thr);
    l1_pkg::beam_vec_t vec;
    for (int b = 0; b < `L1_NBEAMS; b++) begin
        vec[b] = model_power(cur, prev, b) > int'(thr[b]);
    end
    return vec;
endfunction

// Threshold after one period end
function automatic l1_pkg::thresh_t model_servo(input int thr, input int cnt,
                                                input int target, input int margin);
    int stepped;
    stepped = thr;
    if (cnt > target + margin) begin
        stepped = thr + int'(`L1_KP);
    end else if (cnt < target - margin) begin
        stepped = thr - int'(`L1_KP);
    end
    if (stepped < 0) begin
        stepped = 0;                                            // Saturate at zero
    end
    if (stepped > (1 << `L1_THRESH_BITS) - 1) begin
        stepped = (1 << `L1_THRESH_BITS) - 1;
    end
    return l1_pkg::thresh_t'(stepped);
endfunction

`endif

/* verif/l1_trigger_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l1_consts.svh"

module l1_trigger_tb;

    `include "l1_tb_model.svh"

    localparam int ACK_TIMEOUT  = 8;
    localparam int POLL_TIMEOUT = 60;      // Reads of the periods register
    localparam int NROWS        = 7;

    typedef struct packed {
        l1_pkg::sample_t    amp;
        logic               beam;
        l1_pkg::beam_vec_t  exp_vec;
        l1_pkg::thresh_t    thresh;
    } trig_row_t;

    // Pulse beam sees about 8 x amp and the other one about 4 x amp
    localparam trig_row_t ROWS [NROWS] = '{
        '{12'sd400,   1'b0, 2'b01, 18'd2400},
        '{12'sd400,   1'b1, 2'b10, 18'd2400},
        '{12'sd400,   1'b0, 2'b11, 18'd1000},
        '{12'sd400,   1'b1, 2'b00, 18'd4000},
        '{12'sd1000,  1'b1, 2'b10, 18'd6000},
        '{12'sd2000,  1'b0, 2'b01, 18'd15000},
        '{-12'sd1500, 1'b1, 2'b10, 18'd11000}
    };

    logic                   wbclk;
    logic                   rst_n_i;
    l1_pkg::adc_block_t     samples_i;
    logic                   wb_cyc_i;
    logic                   wb_stb_i;
    logic                   wb_we_i;
    logic [21:0]            wb_adr_i;
    logic [31:0]            wb_dat_i;
    logic                   wb_ack_o;
    logic [31:0]            wb_dat_o;
    l1_pkg::beam_vec_t      trigger_o;

    int                     errors;
    int                     checks;
    int                     accesses;
    int                     acks;
    int                     trig_seen [`L1_NBEAMS];            // Expected triggers this period
    l1_pkg::thresh_t [`L1_NBEAMS-1:0] thr_now;                 // As last written
    event                   timeout_ev;

    l1_trigger_top i_dut (.*);

    initial begin
        wbclk = 1'b0;
        forever #10 wbclk = ~wbclk;
    end

    always @(negedge wbclk) begin
        if (wb_ack_o === 1'b1) begin
            acks++;
        end
    end

    // Ends the run after any wait gave up
    initial begin
        @(timeout_ev);
        $display("Testbench failed");
        $finish;
    end

    task automatic check_trigger(input string name, input l1_pkg::beam_vec_t exp,
                                 input l1_pkg::beam_vec_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_thresh(input string name, input l1_pkg::thresh_t exp,
                                input l1_pkg::thresh_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input l1_pkg::count_t exp,
                               input l1_pkg::count_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        -> timeout_ev;
    endtask

    task automatic bus_access(input logic we, input logic [21:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(posedge wbclk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= wdat;
        do begin
            @(negedge wbclk);
            waited++;
            if (waited > ACK_TIMEOUT) begin
                report_timeout("wb_ack_o");
            end
        end while (wb_ack_o !== 1'b1);
        rdat = wb_dat_o;
        accesses++;
        @(posedge wbclk);
        wb_cyc_i <= 1'b0;                                       // stb falls between accesses
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic bus_write(input logic [21:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic bus_read(input logic [21:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, adr, 32'd0, rdat);
    endtask

    task automatic set_thresholds(input l1_pkg::thresh_t t0, input l1_pkg::thresh_t t1);
        bus_write(`L1_REG_THRESH0, 32'(t0));
        bus_write(`L1_REG_THRESH1, 32'(t1));
        thr_now[0] = t0;
        thr_now[1] = t1;
    endtask

    // Noise everywhere with the pulse lined up on one beam's delays
    function automatic l1_pkg::adc_block_t make_pulse(input l1_pkg::sample_t amp, input int beam);
        l1_pkg::adc_block_t blk;
        for (int ch = 0; ch < `L1_NCHAN; ch++) begin
            for (int k = 0; k < `L1_NSAMP; k++) begin
                blk[ch][k] = l1_pkg::sample_t'(int'($urandom % 7) - 3);
            end
            blk[ch][`L1_NSAMP - 1 - MODEL_DELAYS[beam][ch]] = amp;
        end
        return blk;
    endfunction

    // One pulse block between quiet blocks with its trigger 3 cycles later
    task automatic send_pulse(input l1_pkg::adc_block_t blk, input string name);
        l1_pkg::adc_block_t quiet;
        l1_pkg::beam_vec_t  exp_main;
        l1_pkg::beam_vec_t  exp_tail;
        quiet    = '0;
        exp_main = model_trigger(blk, quiet, thr_now);
        exp_tail = model_trigger(quiet, blk, thr_now);          // Leftover of the pulse block
        @(posedge wbclk);
        samples_i <= blk;
        @(posedge wbclk);
        samples_i <= quiet;
        repeat (2) @(posedge wbclk);
        @(negedge wbclk);
        check_trigger(name, exp_main, trigger_o);
        @(negedge wbclk);
        check_trigger({name, " tail"}, exp_tail, trigger_o);
        for (int b = 0; b < `L1_NBEAMS; b++) begin
            trig_seen[b] += int'(exp_main[b]) + int'(exp_tail[b]);
        end
    endtask

    task automatic wait_period_end(input logic [31:0] from, output logic [31:0] now);
        int polls;
        polls = 0;
        bus_read(`L1_REG_PERIODS, now);
        while (now == from) begin
            polls++;
            if (polls > POLL_TIMEOUT) begin
                report_timeout("the end of a servo period");
            end
            bus_read(`L1_REG_PERIODS, now);
        end
    endtask

    task automatic run_period(input string name, input int n0, input int n1,
                              input l1_pkg::count_t target, input l1_pkg::count_t margin);
        logic [31:0] p_start;
        logic [31:0] p_end;
        logic [31:0] rd;
        bus_read(`L1_REG_PERIODS, rd);
        wait_period_end(rd, p_start);                           // Start just after a boundary
        set_thresholds(18'd2400, 18'd2400);
        bus_write(`L1_REG_TARGET, 32'(target));
        bus_write(`L1_REG_MARGIN, 32'(margin));
        trig_seen = '{default: 0};
        repeat (n0) send_pulse(make_pulse(12'sd400, 0), {name, " beam 0"});
        repeat (n1) send_pulse(make_pulse(12'sd400, 1), {name, " beam 1"});
        wait_period_end(p_start, p_end);
        check_word({name, " periods"}, p_start + 32'd1, p_end);
        for (int b = 0; b < `L1_NBEAMS; b++) begin
            bus_read(`L1_REG_COUNT0 + 22'(4 * b), rd);
            check_count($sformatf("%s count%0d", name, b), l1_pkg::count_t'(trig_seen[b]),
                        l1_pkg::count_t'(rd));
            bus_read(`L1_REG_THRESH0 + 22'(4 * b), rd);
            check_thresh($sformatf("%s thresh%0d", name, b),
                         model_servo(thr_now[b], trig_seen[b], target, margin),
                         l1_pkg::thresh_t'(rd));
        end
    endtask

    initial begin
        l1_pkg::adc_block_t quiet;
        l1_pkg::adc_block_t blk;
        logic [31:0]        rd;
        errors    = 0;
        checks    = 0;
        accesses  = 0;
        acks      = 0;
        quiet     = '0;
        void'($urandom(92188));
        rst_n_i   = 1'b0;
        samples_i = '0;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_adr_i  = '0;
        wb_dat_i  = '0;
        repeat (10) @(posedge wbclk);
        rst_n_i <= 1'b1;

        // Reset state is read before the first period ends
        @(negedge wbclk);
        check_trigger("reset trigger", '0, trigger_o);
        bus_read(`L1_REG_THRESH0, rd);
        check_thresh("reset thresh0", `L1_START_THRESH, l1_pkg::thresh_t'(rd));
        bus_read(`L1_REG_THRESH1, rd);
        check_thresh("reset thresh1", `L1_START_THRESH, l1_pkg::thresh_t'(rd));
        bus_read(`L1_REG_TARGET, rd);
        check_count("reset target", `L1_START_TARGET, l1_pkg::count_t'(rd));
        bus_read(`L1_REG_MARGIN, rd);
        check_count("reset margin", `L1_START_MARGIN, l1_pkg::count_t'(rd));
        bus_read(`L1_REG_COUNT0, rd);
        check_count("reset count0", '0, l1_pkg::count_t'(rd));
        bus_read(`L1_REG_COUNT1, rd);
        check_count("reset count1", '0, l1_pkg::count_t'(rd));
        bus_read(`L1_REG_PERIODS, rd);
        check_word("reset periods", 32'd0, rd);

        // Target 0 with margin all ones keeps the servo on hold
        bus_write(`L1_REG_TARGET, 32'd0);
        bus_write(`L1_REG_MARGIN, 32'h0000_ffff);
        bus_read(`L1_REG_TARGET, rd);
        check_count("target readback", 16'd0, l1_pkg::count_t'(rd));
        bus_read(`L1_REG_MARGIN, rd);
        check_count("margin readback", 16'hffff, l1_pkg::count_t'(rd));
        set_thresholds(18'h2a5c3, 18'h01234);
        bus_read(`L1_REG_THRESH0, rd);
        check_thresh("thresh0 readback", 18'h2a5c3, l1_pkg::thresh_t'(rd));
        bus_read(`L1_REG_THRESH1, rd);
        check_thresh("thresh1 readback", 18'h01234, l1_pkg::thresh_t'(rd));
        bus_read(22'h1c, rd);
        check_word("unused 0x1c", 32'd0, rd);
        bus_write(22'h40, 32'hdead_beef);
        bus_read(22'h40, rd);
        check_word("unused 0x40", 32'd0, rd);

        for (int r = 0; r < NROWS; r++) begin
            set_thresholds(ROWS[r].thresh, ROWS[r].thresh);
            blk = make_pulse(ROWS[r].amp, int'(ROWS[r].beam));
            check_trigger($sformatf("row %0d table", r), ROWS[r].exp_vec,
                          model_trigger(blk, quiet, thr_now));
            send_pulse(blk, $sformatf("row %0d", r));
        end

        run_period("period up/down", 3, 1, 16'd2, 16'd0);
        run_period("period hold", 2, 2, 16'd2, 16'd1);

        check_word("ack pulses", 32'(accesses), 32'(acks));
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/l1_trigger_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l1_consts.svh"

module l1_trigger_top (
    input  logic                wbclk,
    input  logic                rst_n_i,
    input  l1_pkg::adc_block_t  samples_i,
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [21:0]         wb_adr_i,
    input  logic [31:0]         wb_dat_i,
    output logic                wb_ack_o,
    output logic [31:0]         wb_dat_o,
    output l1_pkg::beam_vec_t   trigger_o
);

    l1_pkg::power_t  [`L1_NBEAMS-1:0]   power;
    l1_pkg::thresh_t [`L1_NBEAMS-1:0]   thresh;
    l1_pkg::count_t  [`L1_NBEAMS-1:0]   count;
    logic [31:0]                        periods;
    l1_pkg::beam_vec_t                  thresh_wr;
    l1_pkg::thresh_t                    thresh_wdata;
    l1_pkg::count_t                     target;
    l1_pkg::count_t                     margin;

    beam_power i_beam_power (
        .rst_n_i    (rst_n_i),
        .wbclk      (wbclk),
        .samples_i  (samples_i),
        .power_o    (power)
    );

    trigger_servo #(
        .PERIOD_CLOCKS  (`L1_PERIOD_CLOCKS)
    ) i_trigger_servo (
        .rst_n_i        (rst_n_i),
        .wbclk          (wbclk),
        .power_i        (power),
        .thresh_wr_i    (thresh_wr),
        .thresh_wdata_i (thresh_wdata),
        .target_i       (target),
        .margin_i       (margin),
        .trigger_o      (trigger_o),
        .thresh_o       (thresh),
        .count_o        (count),
        .periods_o      (periods)
    );

    l1_wb_regs i_l1_wb_regs (
        .rst_n_i        (rst_n_i),
        .wbclk          (wbclk),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .thresh_i       (thresh),
        .count_i        (count),
        .periods_i      (periods),
        .wb_ack_o       (wb_ack_o),
        .wb_dat_o       (wb_dat_o),
        .thresh_wr_o    (thresh_wr),
        .thresh_wdata_o (thresh_wdata),
        .target_o       (target),
        .margin_o       (margin)
    );

endmodule

`default_nettype wire

/* hdl/l1_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l1_consts.svh"

module l1_wb_regs (
    input  logic                                  rst_n_i,
    input  logic                                  wbclk,
    input  logic                                  wb_cyc_i,
    input  logic                                  wb_stb_i,
    input  logic                                  wb_we_i,
    input  logic [21:0]                           wb_adr_i,
    input  logic [31:0]                           wb_dat_i,
    input  l1_pkg::thresh_t [`L1_NBEAMS-1:0]      thresh_i,
    input  l1_pkg::count_t  [`L1_NBEAMS-1:0]      count_i,
    input  logic [31:0]                           periods_i,
    output logic                                  wb_ack_o,
    output logic [31:0]                           wb_dat_o,
    output l1_pkg::beam_vec_t                     thresh_wr_o,
    output l1_pkg::thresh_t                       thresh_wdata_o,
    output l1_pkg::count_t                        target_o,
    output l1_pkg::count_t                        margin_o
);

    logic           access;
    logic           held_q;     // Access already acked, waiting for stb to drop
    logic           take;       // First cycle of an access
    logic           wr_en;
    logic [31:0]    rd_data;

    assign access = wb_cyc_i && wb_stb_i;
    assign take   = access && !wb_ack_o && !held_q;
    assign wr_en  = take && wb_we_i;

    // Single-cycle ack, one per access
    always_ff @(posedge wbclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
            held_q   <= 1'b0;
        end else begin
            wb_ack_o <= take;
            held_q   <= access && (held_q || wb_ack_o);
        end
    end

    // Threshold writes go straight to the servo, same edge as the ack
    assign thresh_wr_o[0] = wr_en && (wb_adr_i == `L1_REG_THRESH0);
    assign thresh_wr_o[1] = wr_en && (wb_adr_i == `L1_REG_THRESH1);
    assign thresh_wdata_o = wb_dat_i[`L1_THRESH_BITS-1:0];

    always_ff @(posedge wbclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            target_o <= `L1_START_TARGET;
            margin_o <= `L1_START_MARGIN;
        end else if (wr_en) begin
            if (wb_adr_i == `L1_REG_TARGET) begin
                target_o <= wb_dat_i[`L1_COUNT_BITS-1:0];
            end
            if (wb_adr_i == `L1_REG_MARGIN) begin
                margin_o <= wb_dat_i[`L1_COUNT_BITS-1:0];
            end
        end
    end

    // Read mux
    always_comb begin
        case (wb_adr_i)
            `L1_REG_PERIODS: rd_data = periods_i;
            `L1_REG_THRESH0: rd_data = 32'(thresh_i[0]);
            `L1_REG_THRESH1: rd_data = 32'(thresh_i[1]);
            `L1_REG_COUNT0:  rd_data = 32'(count_i[0]);
            `L1_REG_COUNT1:  rd_data = 32'(count_i[1]);
            `L1_REG_TARGET:  rd_data = 32'(target_o);
            `L1_REG_MARGIN:  rd_data = 32'(margin_o);
            default:         rd_data = 32'd0;               // Unused offsets
        endcase
    end

    // Captured with the ack so it is stable while ack is high
    always_ff @(posedge wbclk) begin
        if (take) begin
            wb_dat_o <= rd_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/trigger_servo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l1_consts.svh"

module trigger_servo #(
    parameter int PERIOD_CLOCKS = `L1_PERIOD_CLOCKS
) (
    input  logic                                  rst_n_i,
    input  logic                                  wbclk,
    input  l1_pkg::power_t  [`L1_NBEAMS-1:0]      power_i,
    input  l1_pkg::beam_vec_t                     thresh_wr_i,
    input  l1_pkg::thresh_t                       thresh_wdata_i,
    input  l1_pkg::count_t                        target_i,
    input  l1_pkg::count_t                        margin_i,
    output l1_pkg::beam_vec_t                     trigger_o,
    output l1_pkg::thresh_t [`L1_NBEAMS-1:0]      thresh_o,
    output l1_pkg::count_t  [`L1_NBEAMS-1:0]      count_o,
    output logic [31:0]                           periods_o
);

    localparam int CNT_W = $clog2(PERIOD_CLOCKS);

    logic [CNT_W-1:0]                       clk_cnt_q;
    logic                                   period_end;
    l1_pkg::count_t [`L1_NBEAMS-1:0]        run_cnt_q;
    l1_pkg::count_t [`L1_NBEAMS-1:0]        total;      // Including this cycle's trigger

    // One servo correction for one beam
    function automatic l1_pkg::thresh_t servo_step(
        input l1_pkg::thresh_t thr,
        input l1_pkg::count_t  cnt,
        input l1_pkg::count_t  target,
        input l1_pkg::count_t  margin
    );
        logic [`L1_COUNT_BITS:0]  hi;
        logic [`L1_COUNT_BITS:0]  lo;
        logic [`L1_THRESH_BITS:0] up;
        hi = target + margin;
        lo = cnt + margin;
        up = thr + `L1_KP;
        if (cnt > hi) begin                                     // Too many, raise
            return up[`L1_THRESH_BITS] ? '1 : up[`L1_THRESH_BITS-1:0];
        end else if (lo < target) begin                         // Too few, lower
            return (thr >= `L1_KP) ? l1_pkg::thresh_t'(thr - `L1_KP) : '0;
        end
        return thr;
    endfunction

    assign period_end = (clk_cnt_q == CNT_W'(PERIOD_CLOCKS - 1));

    always_comb begin
        for (int b = 0; b < `L1_NBEAMS; b++) begin
            total[b] = run_cnt_q[b] + l1_pkg::count_t'(trigger_o[b]);
        end
    end

    // Registered compare, strictly greater
    always_ff @(posedge wbclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            trigger_o <= '0;
        end else begin
            for (int b = 0; b < `L1_NBEAMS; b++) begin
                trigger_o[b] <= (power_i[b] > thresh_o[b]);
            end
        end
    end

    // Period timer, also counts completed periods
    always_ff @(posedge wbclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            clk_cnt_q <= '0;
            periods_o <= '0;
        end else if (period_end) begin
            clk_cnt_q <= '0;
            periods_o <= periods_o + 32'd1;
        end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge wbclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_cnt_q <= '0;
            count_o   <= '0;
            for (int b = 0; b < `L1_NBEAMS; b++) begin
                thresh_o[b] <= `L1_START_THRESH;
            end
        end else begin
            for (int b = 0; b < `L1_NBEAMS; b++) begin
                if (period_end) begin
                    count_o[b]   <= total[b];
                    run_cnt_q[b] <= '0;
                end else begin
                    run_cnt_q[b] <= total[b];
                end
                if (thresh_wr_i[b]) begin                       // Bus write beats the step
                    thresh_o[b] <= thresh_wdata_i;
                end else if (period_end) begin
                    thresh_o[b] <= servo_step(thresh_o[b], total[b], target_i, margin_i);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/beam_power.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l1_consts.svh"

module beam_power (
    input  logic                                  rst_n_i,
    input  logic                                  wbclk,
    input  l1_pkg::adc_block_t                    samples_i,
    output l1_pkg::power_t [`L1_NBEAMS-1:0]       power_o
);

    localparam int DELAYS [`L1_NBEAMS][`L1_NCHAN] = `L1_BEAM_DELAYS;

    l1_pkg::adc_block_t     prev_q;                             // Last block, all channels
    l1_pkg::beam_sample_t   beam_d [`L1_NBEAMS][`L1_NSAMP];
    l1_pkg::beam_sample_t   beam_q [`L1_NBEAMS][`L1_NSAMP];
    l1_pkg::power_t         power_d [`L1_NBEAMS];

    // Sample idx of a channel, negative idx reaches into the previous block
    function automatic l1_pkg::sample_t pick_sample(
        input l1_pkg::adc_block_t cur,
        input l1_pkg::adc_block_t prev,
        input int                 ch,
        input int                 idx
    );
        if (idx >= 0) begin
            return l1_pkg::sample_t'(cur[ch][idx]);
        end
        return l1_pkg::sample_t'(prev[ch][idx + `L1_NSAMP]);
    endfunction

    // Magnitude, widened first so -16384 does not wrap
    function automatic l1_pkg::power_t abs_beam(input l1_pkg::beam_sample_t x);
        logic signed [`L1_BEAM_BITS:0] wide;
        wide = x;
        if (wide < 0) begin
            wide = -wide;
        end
        return l1_pkg::power_t'(wide);
    endfunction

    always_ff @(posedge wbclk) begin
        prev_q <= samples_i;
    end

    // Stage one: align and sum the channels
    always_comb begin
        for (int b = 0; b < `L1_NBEAMS; b++) begin
            for (int n = 0; n < `L1_NSAMP; n++) begin
                beam_d[b][n] = '0;
                for (int ch = 0; ch < `L1_NCHAN; ch++) begin
                    beam_d[b][n] = beam_d[b][n]
                                 + pick_sample(samples_i, prev_q, ch, n - DELAYS[b][ch]);
                end
            end
        end
    end

    always_ff @(posedge wbclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int b = 0; b < `L1_NBEAMS; b++) begin
                for (int n = 0; n < `L1_NSAMP; n++) begin
                    beam_q[b][n] <= '0;
                end
            end
        end else begin
            beam_q <= beam_d;
        end
    end

    // Stage two: block power
    always_comb begin
        for (int b = 0; b < `L1_NBEAMS; b++) begin
            power_d[b] = '0;
            for (int n = 0; n < `L1_NSAMP; n++) begin
                power_d[b] = power_d[b] + abs_beam(beam_q[b][n]);
            end
        end
    end

    always_ff @(posedge wbclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            power_o <= '0;
        end else begin
            for (int b = 0; b < `L1_NBEAMS; b++) begin
                power_o[b] <= power_d[b];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/l1_pkg.sv */
`default_nettype none

`include "l1_consts.svh"

package l1_pkg;

    // Raw ADC sample, two's complement
    typedef logic signed [`L1_NBITS-1:0] sample_t;

    // One channel's block, sample 0 is the oldest
    typedef sample_t [`L1_NSAMP-1:0] chan_block_t;

    // Every channel for one wbclk
    typedef chan_block_t [`L1_NCHAN-1:0] adc_block_t;

    // Sum of all channels after delay alignment
    typedef logic signed [`L1_BEAM_BITS-1:0] beam_sample_t;

    // Sum of beam magnitudes over one block
    typedef logic [`L1_POWER_BITS-1:0] power_t;

    typedef logic [`L1_THRESH_BITS-1:0] thresh_t;

    // Triggers seen in one servo period
    typedef logic [`L1_COUNT_BITS-1:0] count_t;

    // One bit per beam
    typedef logic [`L1_NBEAMS-1:0] beam_vec_t;

endpackage

`default_nettype wire

/* hdl/l1_consts.svh */
`ifndef L1_CONSTS_SVH
`define L1_CONSTS_SVH

// Array geometry
`define L1_NCHAN        8
`define L1_NSAMP        8
`define L1_NBITS        12
`define L1_NBEAMS       2

// Derived widths
`define L1_BEAM_BITS    15      // NBITS plus log2 of NCHAN
`define L1_POWER_BITS   18      // Holds 64 x 2048
`define L1_THRESH_BITS  18
`define L1_COUNT_BITS   16

// Per beam, per channel delay in samples, each 0 to 7.
// Beam 0 looks one way across the array, beam 1 the other way.
`define L1_BEAM_DELAYS  '{ '{0, 1, 2, 3, 4, 5, 6, 7}, '{7, 6, 5, 4, 3, 2, 1, 0} }

// Rate servo defaults
`define L1_PERIOD_CLOCKS    64
`define L1_START_THRESH     18'd3000
`define L1_START_TARGET     16'd8       // Triggers per period
`define L1_START_MARGIN     16'd2       // Plus or minus on the count
`define L1_KP               18'd100     // Threshold step per correction

// Wishbone byte offsets
`define L1_REG_PERIODS  22'h00
`define L1_REG_THRESH0  22'h04
`define L1_REG_THRESH1  22'h08
`define L1_REG_COUNT0   22'h0C
`define L1_REG_COUNT1   22'h10
`define L1_REG_TARGET   22'h14
`define L1_REG_MARGIN   22'h18

`endif
